// File: list.f
hw/frontend_pkg.sv
hw/pc_gen.sv
hw/fetch_unit.sv
hw/multi_channel_fifo.sv
hw/inst_decoder.sv
hw/frontend.sv
testbench/tb_frontend.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frontend -f list.f -o sim_frontend

output=$(./obj_dir/sim_frontend 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module tb_frontend;

    localparam int RESET_CYCLES = 4;
    localparam int N_ROWS       = 11;
    localparam int ACT_NONE     = 0;
    localparam int ACT_REDIRECT = 1;
    localparam int ACT_IDLE     = 2;
    localparam int ACT_INT      = 3;
    localparam int ISSUE_RAND   = 3;
    localparam int STALL_RAND   = 2;

    typedef struct {
        int          cycles;
        int          mode;
        int          stall;
        int          act;
        logic [31:0] target;
    } row_t;

    logic                       clk;
    logic                       rst_n;
    logic                       redirect_i;
    logic [31:0]                redirect_pc_i;
    logic                       idle_i;
    logic                       int_i;
    logic                       imem_req_o;
    logic [31:0]                imem_addr_o;
    logic [63:0]                imem_rdata_i;
    frontend_pkg::inst_t [1:0]  inst_o;
    logic [1:0]                 inst_valid_o;
    logic [1:0]                 issue_num_i;
    logic                       backend_stall_i;

    logic [31:0] word_table [64];
    row_t        rows [N_ROWS];
    logic        mem_pending = 1'b0;
    logic [31:0] mem_addr;
    logic [31:0] exp_pc;
    logic [31:0] exp_addr;
    logic        locked;
    logic        saw_both;
    int          popped_total;
    int          cycle_count = 0;
    int          cycle_limit = RESET_CYCLES + 200;

    frontend DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .idle_i          (idle_i),
        .int_i           (int_i),
        .imem_req_o      (imem_req_o),
        .imem_addr_o     (imem_addr_o),
        .imem_rdata_i    (imem_rdata_i),
        .inst_o          (inst_o),
        .inst_valid_o    (inst_valid_o),
        .issue_num_i     (issue_num_i),
        .backend_stall_i (backend_stall_i)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one-cycle memory driving its data on the falling edge
    always @(posedge clk) begin
        mem_pending <= imem_req_o;
        mem_addr    <= imem_addr_o;
    end

    always @(negedge clk) begin
        if (mem_pending) begin
            imem_rdata_i <= {word_table[mem_addr[7:2] + 6'd1], word_table[mem_addr[7:2]]};
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    function automatic frontend_pkg::inst_t with_regs(input frontend_pkg::inst_t e,
                                                      input logic [3:0] rtype,
                                                      input logic [4:0] r0,
                                                      input logic [4:0] r1,
                                                      input logic [4:0] w);
        frontend_pkg::inst_t o;
        o          = e;
        o.reg_type = rtype;
        o.r_reg0   = r0;
        o.r_reg1   = r1;
        o.w_reg    = w;
        return o;
    endfunction

    // expected entry for a pc from the register usage table
    function automatic frontend_pkg::inst_t expected_entry(input logic [31:0] pc);
        frontend_pkg::inst_t e;
        logic [4:0]          rk;
        logic [4:0]          rj;
        logic [4:0]          rd;
        e.pc   = pc;
        e.inst = word_table[pc[7:2]];
        rk     = e.inst[14:10];
        rj     = e.inst[9:5];
        rd     = e.inst[4:0];
        case (e.inst[31:28])
            4'd0:    e = with_regs(e, frontend_pkg::REG_RRW, rk, rj, rd);
            4'd1:    e = with_regs(e, frontend_pkg::REG_RW, 5'd0, rj, rd);
            4'd2:    e = with_regs(e, frontend_pkg::REG_RR, rd, rj, 5'd0);
            4'd3:    e = with_regs(e, frontend_pkg::REG_BL, 5'd0, 5'd0, 5'd1);
            4'd4:    e = with_regs(e, frontend_pkg::REG_W, rk, rj, rd);
            4'd5:    e = with_regs(e, frontend_pkg::REG_CSRXCHG, rd, rj, rd);
            4'd6:    e = with_regs(e, frontend_pkg::REG_RDCNTID, 5'd0, 5'd0, rd | rj);
            4'd7:    e = with_regs(e, frontend_pkg::REG_INVTLB, rk, rj, 5'd0);
            default: e = with_regs(e, frontend_pkg::REG_I, 5'd0, 5'd0, 5'd0);
        endcase
        return e;
    endfunction

    task automatic check_entry(input frontend_pkg::inst_t got);
        frontend_pkg::inst_t want;
        want = expected_entry(exp_pc);
        assert (got.pc == want.pc)
            else report_error($sformatf("pc %h, expected %h", got.pc, want.pc));
        assert (got.inst == want.inst)
            else report_error($sformatf("inst %h at pc %h, expected %h",
                                        got.inst, got.pc, want.inst));
        assert (got.reg_type == want.reg_type && got.r_reg0 == want.r_reg0 &&
                got.r_reg1 == want.r_reg1 && got.w_reg == want.w_reg)
            else report_error($sformatf("decode of %h: type %0d regs %0d %0d %0d",
                                        got.inst, got.reg_type, got.r_reg0,
                                        got.r_reg1, got.w_reg));
        exp_pc       = exp_pc + 32'd4;
        popped_total = popped_total + 1;
    endtask

    // checks and drives for one falling edge
    task automatic step_cycle(input row_t row, input bit first, input bit last);
        int valid_cnt;
        int want;
        bit stall;
        // request taken by the memory at the last rising edge
        if (mem_pending) begin
            assert (mem_addr == exp_addr)
                else report_error($sformatf("fetch address %h, expected %h",
                                            mem_addr, exp_addr));
            exp_addr = exp_addr + 32'd8;
        end
        if (locked) begin
            assert (!imem_req_o) else report_error("fetch request while idle lock is set");
        end
        if (last && row.act == ACT_IDLE) begin
            assert (inst_valid_o == 2'b00) else report_error("entries still arrive when idle");
        end
        redirect_i = 1'b0;
        idle_i     = 1'b0;
        int_i      = 1'b0;
        valid_cnt  = inst_valid_o[0] + inst_valid_o[1];
        want       = (row.mode == ISSUE_RAND) ? $urandom_range(0, 2) : row.mode;
        stall      = (row.stall == STALL_RAND) ? 1'($urandom_range(0, 1)) : 1'(row.stall);
        if (want > valid_cnt) begin
            want = valid_cnt;
        end
        if (first && row.act == ACT_REDIRECT) begin
            redirect_i    = 1'b1;
            redirect_pc_i = row.target;
            want          = 0;
        end
        idle_i          = first && row.act == ACT_IDLE;
        int_i           = first && row.act == ACT_INT;
        issue_num_i     = 2'(want);
        backend_stall_i = stall;
        if (stall && inst_valid_o == 2'b11) begin
            saw_both = 1'b1;
        end
        if (!stall) begin
            for (int i = 0; i < want; i++) begin
                check_entry(inst_o[i]);
            end
        end
        if (redirect_i) begin
            exp_pc   = {row.target[31:2], 2'b00};
            exp_addr = {row.target[31:3], 3'b000};
        end
        if (idle_i) begin
            locked = 1'b1;
        end
        if (int_i) begin
            locked = 1'b0;
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        redirect_i      = 1'b0;
        redirect_pc_i   = '0;
        idle_i          = 1'b0;
        int_i           = 1'b0;
        issue_num_i     = 2'd0;
        backend_stall_i = 1'b0;
        imem_rdata_i    = '0;
        exp_pc          = '0;
        exp_addr        = '0;
        locked          = 1'b0;
        saw_both        = 1'b0;
        popped_total    = 0;

        void'($urandom(32'hae31_1734));
        for (int i = 0; i < 64; i++) begin
            word_table[i] = $urandom();
        end

        // cycles, issue mode, stall, action, target
        rows[0]  = '{40, 2, 0, ACT_NONE, 32'h0};
        rows[1]  = '{60, ISSUE_RAND, STALL_RAND, ACT_NONE, 32'h0};
        rows[2]  = '{30, 0, 1, ACT_NONE, 32'h0};
        rows[3]  = '{30, 2, 0, ACT_REDIRECT, 32'h0000_0100};
        rows[4]  = '{40, ISSUE_RAND, STALL_RAND, ACT_NONE, 32'h0};
        rows[5]  = '{30, 1, 0, ACT_REDIRECT, 32'h0000_0a4c};
        rows[6]  = '{40, 2, 0, ACT_IDLE, 32'h0};
        rows[7]  = '{20, 2, 0, ACT_NONE, 32'h0};
        rows[8]  = '{40, ISSUE_RAND, STALL_RAND, ACT_INT, 32'h0};
        rows[9]  = '{12, 0, 1, ACT_REDIRECT, 32'h0000_0014};
        rows[10] = '{40, 2, 0, ACT_NONE, 32'h0};
        for (int r = 0; r < N_ROWS; r++) begin
            cycle_limit = cycle_limit + rows[r].cycles;
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (inst_valid_o == 2'b00 && !imem_req_o)
                else report_error("frontend active while in reset");
        end
        rst_n = 1'b1;

        for (int r = 0; r < N_ROWS; r++) begin
            for (int c = 0; c < rows[r].cycles; c++) begin
                @(negedge clk);
                step_cycle(rows[r], c == 0, c == rows[r].cycles - 1);
            end
        end

        assert (saw_both) else report_error("stalled backend never saw two valid entries");
        assert (popped_total > 150) else report_error("too few entries reached the backend");
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/frontend.sv
`timescale 1ns/1ns
`default_nettype none

module frontend (
    input  wire                             clk,
    input  wire                             rst_n,

    // redirect from the backend
    input  wire                             redirect_i,
    input  wire [frontend_pkg::XLEN-1:0]    redirect_pc_i,

    // idle lock
    input  wire                             idle_i,
    input  wire                             int_i,

    // instruction memory
    output logic                            imem_req_o,
    output logic [frontend_pkg::XLEN-1:0]   imem_addr_o,
    input  wire [2*frontend_pkg::XLEN-1:0]  imem_rdata_i,

    // backend
    output frontend_pkg::inst_t [1:0]       inst_o,
    output logic [1:0]                      inst_valid_o,
    input  wire [1:0]                       issue_num_i,
    input  wire                             backend_stall_i
);

    logic [frontend_pkg::XLEN-1:0]    pc;
    logic                             idle_lock;
    logic                             fetch_advance;
    logic                             raw_ready;
    logic [1:0]                       fetch_write_num;
    frontend_pkg::fetch_entry_t [1:0] fetch_data;
    logic [1:0]                       raw_valid;
    frontend_pkg::fetch_entry_t [1:0] raw_data;
    logic [1:0]                       raw_num;
    logic                             dec_ready;
    frontend_pkg::inst_t [1:0]        dec_data;

    pc_gen u_pc_gen (
        .clk,
        .rst_n,
        .redirect_i,
        .redirect_pc_i,
        .advance_i   (fetch_advance),
        .idle_i,
        .int_i,
        .pc_o        (pc),
        .idle_lock_o (idle_lock)
    );

    fetch_unit u_fetch (
        .clk,
        .rst_n,
        .pc_i         (pc),
        .idle_lock_i  (idle_lock),
        .flush_i      (redirect_i),
        .fifo_ready_i (raw_ready),
        .imem_rdata_i,
        .advance_o    (fetch_advance),
        .imem_req_o,
        .imem_addr_o,
        .write_num_o  (fetch_write_num),
        .write_data_o (fetch_data)
    );

    multi_channel_fifo #(
        .T     (frontend_pkg::fetch_entry_t),
        .DEPTH (frontend_pkg::FIFO_DEPTH)
    ) u_raw_fifo (
        .clk,
        .rst_n,
        .flush_i       (redirect_i),
        .write_num_i   (fetch_write_num),
        .write_data_i  (fetch_data),
        .write_ready_o (raw_ready),
        .read_ready_i  (dec_ready),
        .read_num_i    (raw_num),
        .read_valid_o  (raw_valid),
        .read_data_o   (raw_data)
    );

    // move everything that is valid, valid[1] implies valid[0]
    assign raw_num = {raw_valid[1], raw_valid[0] & ~raw_valid[1]};

    for (genvar i = 0; i < 2; i++) begin : g_dec
        inst_decoder u_dec (
            .inst_i     (raw_data[i].inst),
            .reg_type_o (dec_data[i].reg_type),
            .r_reg0_o   (dec_data[i].r_reg0),
            .r_reg1_o   (dec_data[i].r_reg1),
            .w_reg_o    (dec_data[i].w_reg)
        );
        assign dec_data[i].pc   = raw_data[i].pc;
        assign dec_data[i].inst = raw_data[i].inst;
    end

    multi_channel_fifo #(
        .T     (frontend_pkg::inst_t),
        .DEPTH (frontend_pkg::FIFO_DEPTH)
    ) u_dec_fifo (
        .clk,
        .rst_n,
        .flush_i       (redirect_i),
        .write_num_i   (raw_num),
        .write_data_i  (dec_data),
        .write_ready_o (dec_ready),
        .read_ready_i  (~backend_stall_i),
        .read_num_i    (issue_num_i),
        .read_valid_o  (inst_valid_o),
        .read_data_o   (inst_o)
    );

endmodule

`default_nettype wire

// File: hw/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  wire [frontend_pkg::XLEN-1:0]        inst_i,
    output logic [frontend_pkg::REG_TYPE_W-1:0] reg_type_o,
    output logic [frontend_pkg::REG_W-1:0]      r_reg0_o,
    output logic [frontend_pkg::REG_W-1:0]      r_reg1_o,
    output logic [frontend_pkg::REG_W-1:0]      w_reg_o
);

    logic [frontend_pkg::REG_W-1:0] rk;
    logic [frontend_pkg::REG_W-1:0] rj;
    logic [frontend_pkg::REG_W-1:0] rd;

    assign rk = inst_i[14:10];
    assign rj = inst_i[9:5];
    assign rd = inst_i[4:0];

    // major opcode picks the register usage
    always_comb begin
        case (inst_i[31:28])
            4'd0:    reg_type_o = frontend_pkg::REG_RRW;
            4'd1:    reg_type_o = frontend_pkg::REG_RW;
            4'd2:    reg_type_o = frontend_pkg::REG_RR;
            4'd3:    reg_type_o = frontend_pkg::REG_BL;
            4'd4:    reg_type_o = frontend_pkg::REG_W;
            4'd5:    reg_type_o = frontend_pkg::REG_CSRXCHG;
            4'd6:    reg_type_o = frontend_pkg::REG_RDCNTID;
            4'd7:    reg_type_o = frontend_pkg::REG_INVTLB;
            default: reg_type_o = frontend_pkg::REG_I;
        endcase
    end

    always_comb begin
        r_reg0_o = '0;
        r_reg1_o = '0;
        w_reg_o  = '0;
        case (reg_type_o)
            frontend_pkg::REG_RW: begin
                r_reg1_o = rj;
                w_reg_o  = rd;
            end
            frontend_pkg::REG_RRW,
            frontend_pkg::REG_W: begin
                r_reg0_o = rk;
                r_reg1_o = rj;
                w_reg_o  = rd;
            end
            frontend_pkg::REG_RR: begin
                // stores and branches read rd
                r_reg0_o = rd;
                r_reg1_o = rj;
            end
            frontend_pkg::REG_BL: begin
                // link register r1
                w_reg_o = 5'd1;
            end
            frontend_pkg::REG_CSRXCHG: begin
                r_reg0_o = rd;
                r_reg1_o = rj;
                w_reg_o  = rd;
            end
            frontend_pkg::REG_RDCNTID: begin
                w_reg_o = rd | rj;
            end
            frontend_pkg::REG_INVTLB: begin
                r_reg0_o = rk;
                r_reg1_o = rj;
            end
            default: begin
                w_reg_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/multi_channel_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module multi_channel_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = frontend_pkg::FIFO_DEPTH
) (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          flush_i,

    // write side, up to two per cycle
    input  wire [1:0]    write_num_i,
    input  wire T [1:0]  write_data_i,
    output logic         write_ready_o,

    // read side, slot 0 is the oldest
    input  wire          read_ready_i,
    input  wire [1:0]    read_num_i,
    output logic [1:0]   read_valid_o,
    output T [1:0]       read_data_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] wr_ptr_nxt;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_nxt;
    logic [CNT_W-1:0] count;
    logic [1:0]       push_num;
    logic [1:0]       pop_num;

    // ready only with room for a full pair
    assign write_ready_o = (count <= CNT_W'(DEPTH - 2));

    assign push_num = write_ready_o ? write_num_i : 2'd0;
    assign pop_num  = read_ready_i ? read_num_i : 2'd0;

    assign wr_ptr_nxt = wr_ptr + 1'b1;
    assign rd_ptr_nxt = rd_ptr + 1'b1;

    assign read_valid_o[0] = (count > CNT_W'(0));
    assign read_valid_o[1] = (count > CNT_W'(1));

    assign read_data_o[0] = mem[rd_ptr];
    assign read_data_o[1] = mem[rd_ptr_nxt];

    // storage
    always_ff @(posedge clk) begin
        if (push_num != 2'd0) begin
            mem[wr_ptr] <= write_data_i[0];
        end
        if (push_num == 2'd2) begin
            mem[wr_ptr_nxt] <= write_data_i[1];
        end
    end

    // pointers and fill level
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push_num);
            rd_ptr <= rd_ptr + PTR_W'(pop_num);
            count  <= count + CNT_W'(push_num) - CNT_W'(pop_num);
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire [frontend_pkg::XLEN-1:0]       pc_i,
    input  wire                                idle_lock_i,
    input  wire                                flush_i,
    input  wire                                fifo_ready_i,
    input  wire [2*frontend_pkg::XLEN-1:0]     imem_rdata_i,
    output logic                               advance_o,
    output logic                               imem_req_o,
    output logic [frontend_pkg::XLEN-1:0]      imem_addr_o,
    output logic [1:0]                         write_num_o,
    output frontend_pkg::fetch_entry_t [1:0]   write_data_o
);

    localparam int XL = frontend_pkg::XLEN;

    logic                             fetch_en;
    logic                             inflight_valid;
    logic [XL-1:0]                    inflight_pc;
    logic                             hold_valid;
    logic [1:0]                       hold_num;
    frontend_pkg::fetch_entry_t [1:0] hold_data;
    logic [1:0]                       resp_num;
    frontend_pkg::fetch_entry_t [1:0] resp_data;
    logic                             stall;

    assign stall       = hold_valid | ~fifo_ready_i | idle_lock_i;
    assign imem_req_o  = fetch_en & ~stall & ~flush_i;
    assign imem_addr_o = {pc_i[XL-1:3], 3'b000};
    assign advance_o   = imem_req_o;

    // pack the returned pair into slots
    always_comb begin
        resp_data[1].pc   = {inflight_pc[XL-1:3], 3'b100};
        resp_data[1].inst = imem_rdata_i[2*XL-1:XL];
        if (inflight_pc[2]) begin
            // lone high word goes to slot 0
            resp_data[0] = resp_data[1];
            resp_num     = {1'b0, inflight_valid};
        end else begin
            resp_data[0].pc   = {inflight_pc[XL-1:3], 3'b000};
            resp_data[0].inst = imem_rdata_i[XL-1:0];
            resp_num          = {inflight_valid, 1'b0};
        end
    end

    // held pair goes out before anything new
    always_comb begin
        if (hold_valid) begin
            write_data_o = hold_data;
            write_num_o  = fifo_ready_i ? hold_num : 2'd0;
        end else begin
            write_data_o = resp_data;
            write_num_o  = fifo_ready_i ? resp_num : 2'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_en       <= 1'b0;
            inflight_valid <= 1'b0;
            hold_valid     <= 1'b0;
        end else begin
            fetch_en       <= 1'b1;
            inflight_valid <= imem_req_o;
            if (flush_i) begin
                hold_valid <= 1'b0;
            end else if (hold_valid) begin
                hold_valid <= ~fifo_ready_i;
            end else if (inflight_valid && !fifo_ready_i) begin
                hold_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req_o) begin
            inflight_pc <= pc_i;
        end
        if (!hold_valid) begin
            hold_data <= resp_data;
            hold_num  <= resp_num;
        end
    end

endmodule

`default_nettype wire

// File: hw/pc_gen.sv
`timescale 1ns/1ns
`default_nettype none

module pc_gen (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           redirect_i,
    input  wire [frontend_pkg::XLEN-1:0]  redirect_pc_i,
    input  wire                           advance_i,
    input  wire                           idle_i,
    input  wire                           int_i,
    output logic [frontend_pkg::XLEN-1:0] pc_o,
    output logic                          idle_lock_o
);

    logic [frontend_pkg::XLEN-1:0] pc_q;
    logic                          idle_lock_q;

    // redirect wins over advance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= {redirect_pc_i[frontend_pkg::XLEN-1:2], 2'b00};
        end else if (advance_i) begin
            // next aligned pair, odd-word start falls back to the base
            pc_q <= {pc_q[frontend_pkg::XLEN-1:3] + 1'b1, 3'b000};
        end
    end

    // idle holds until an interrupt shows up
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idle_lock_q <= 1'b0;
        end else if (idle_i && !int_i) begin
            idle_lock_q <= 1'b1;
        end else if (int_i) begin
            idle_lock_q <= 1'b0;
        end
    end

    assign pc_o        = pc_q;
    assign idle_lock_o = idle_lock_q;

endmodule

`default_nettype wire

// File: hw/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    // instruction and pc width
    localparam int XLEN = 32;

    // entries per fifo, power of two
    localparam int FIFO_DEPTH = 8;

    // register-type code width
    localparam int REG_TYPE_W = 4;

    // register-type codes
    localparam logic [REG_TYPE_W-1:0] REG_I       = 4'd0;
    localparam logic [REG_TYPE_W-1:0] REG_RRW     = 4'd1;
    localparam logic [REG_TYPE_W-1:0] REG_RW      = 4'd2;
    localparam logic [REG_TYPE_W-1:0] REG_RR      = 4'd3;
    localparam logic [REG_TYPE_W-1:0] REG_BL      = 4'd4;
    // code of the write type, and also the register number width (5)
    localparam logic [REG_TYPE_W-1:0] REG_W       = 4'd5;
    localparam logic [REG_TYPE_W-1:0] REG_CSRXCHG = 4'd6;
    localparam logic [REG_TYPE_W-1:0] REG_RDCNTID = 4'd7;
    localparam logic [REG_TYPE_W-1:0] REG_INVTLB  = 4'd8;

    // raw fetched word with its address
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_entry_t;

    // decoded entry handed to the backend
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
        logic [REG_TYPE_W-1:0] reg_type;
        logic [REG_W-1:0]      r_reg0;
        logic [REG_W-1:0]      r_reg1;
        logic [REG_W-1:0]      w_reg;
    } inst_t;

endpackage

`default_nettype wire
